//--- design/cb_addr_issue.sv
`timescale 1ns/1ps
// run FSM, one issue beat per cycle with group parity
// drains the shift chain before busy falls
module cb_addr_issue #(
  parameter int GROUP_LEN = 4,
  parameter int L = 4
) (
  input  logic                clk,
  input  logic                sys_rst,
  input  logic                start,
  input  cb_pkg::cb_run_cfg_s run_cfg,
  output cb_pkg::cb_beat_s    beat,
  output cb_pkg::cb_dir_e     run_dir,
  output logic                busy
);
  import cb_pkg::*;

  // beat index bit that holds the group parity
  localparam int GRP_BIT   = $clog2(GROUP_LEN);
  localparam int DRAIN_CYC = L + 2;
  localparam int DRAIN_W   = $clog2(DRAIN_CYC);

  issue_state_e       state;
  run_len_t           beat_cnt;
  run_len_t           run_len;
  cb_addr_t           run_base;
  logic [DRAIN_W-1:0] drain_cnt;

  // config copy for the run
  always_ff @(posedge clk) begin
    if (state == ISSUE_IDLE && start) begin
      run_len  <= run_cfg.len;
      run_base <= run_cfg.base;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= ISSUE_IDLE;
      beat      <= '0;
      run_dir   <= DIR_IDLE;
      beat_cnt  <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        ISSUE_IDLE: begin
          beat      <= '0;
          drain_cnt <= '0;
          if (start) begin
            run_dir <= run_cfg.dir;
            if (run_cfg.len == '0) begin
              // nothing to issue
              state <= ISSUE_DRAIN;
            end else begin
              // beat 0 right after start
              beat.en_new      <= 1'b1;
              beat.addr_new    <= run_cfg.base;
              beat.group_cnt_0 <= 1'b0;
              beat_cnt         <= run_len_t'(1);
              state            <= ISSUE_RUN;
            end
          end
        end
        ISSUE_RUN: begin
          if (beat_cnt == run_len) begin
            beat  <= '0;
            state <= ISSUE_DRAIN;
          end else begin
            beat.en_new      <= 1'b1;
            beat.addr_new    <= run_base + beat_cnt[CB_AW-1:0];
            beat.group_cnt_0 <= beat_cnt[GRP_BIT];
            beat_cnt         <= beat_cnt + 1'b1;
          end
        end
        ISSUE_DRAIN: begin
          // last beat leaves bank L-1 inside this window
          if (drain_cnt == DRAIN_W'(DRAIN_CYC - 1)) begin
            state   <= ISSUE_IDLE;
            run_dir <= DIR_IDLE;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: state <= ISSUE_IDLE;
      endcase
    end
  end

  assign busy = (state != ISSUE_IDLE);

endmodule

//--- design/cb_addr_shift.sv
`timescale 1ns/1ps
// per-bank address and enable shift chain
// positive mapping plus the two bank-pair modes
module cb_addr_shift #(
  parameter int L = 4
) (
  input  logic                     clk,
  input  logic                     sys_rst,
  input  cb_pkg::cb_dir_e          run_dir,
  input  cb_pkg::cb_beat_s         beat,
  output cb_pkg::cb_addr_t [L-1:0] cb_addr,
  output logic [L-1:0]             cb_en
);
  import cb_pkg::*;

  // grp_d[i] is the parity of the beat now in bank i
  logic [L-2:0] grp_d;

  // bank pair used by the new modes
  logic [1:0] pair_lo;
  logic [1:0] pair_hi;

  assign pair_lo = (run_dir == DIR_NEW_0) ? 2'd2 : 2'd0;
  assign pair_hi = pair_lo + 2'd1;

  // parity follows the beat down the chain
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      grp_d <= '0;
    end else if (run_dir != DIR_IDLE) begin
      grp_d <= {grp_d[L-3:0], beat.group_cnt_0};
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cb_addr <= '0;
      cb_en   <= '0;
    end else begin
      case (run_dir)
        DIR_POS: begin
          // bank 0 takes the new address
          cb_en[0]   <= beat.en_new;
          cb_addr[0] <= beat.en_new ? beat.addr_new : '0;
          for (int i = 1; i < L; i++) begin
            cb_en[i] <= cb_en[i-1];
            // odd groups step by one per hop
            if (cb_en[i-1]) begin
              cb_addr[i] <= cb_addr[i-1] + cb_addr_t'(grp_d[i-1]);
            end else begin
              cb_addr[i] <= '0;
            end
          end
        end
        DIR_NEW_0, DIR_NEW_1: begin
          // everything outside the pair drops out
          cb_en   <= '0;
          cb_addr <= '0;
          // pair head loads, tail copies the head
          cb_en[pair_lo]   <= beat.en_new;
          cb_addr[pair_lo] <= beat.en_new ? beat.addr_new : '0;
          cb_en[pair_hi]   <= cb_en[pair_lo];
          cb_addr[pair_hi] <= cb_en[pair_lo] ? cb_addr[pair_lo] : '0;
        end
        default: begin
          // idle: hold
          cb_en   <= cb_en;
          cb_addr <= cb_addr;
        end
      endcase
    end
  end

endmodule

//--- design/cb_bank_read.sv
`timescale 1ns/1ps
// L codebook bank memories
// bus write port, synchronous read at the shifted address, valid
module cb_bank_read #(
  parameter int L = 4
) (
  input  logic                     clk,
  input  logic                     sys_rst,
  input  cb_pkg::cb_addr_t [L-1:0] cb_addr,
  input  logic [L-1:0]             cb_en,
  input  logic                     mem_wr_en,
  input  cb_pkg::cb_bank_t         mem_wr_bank,
  input  cb_pkg::cb_addr_t         mem_wr_addr,
  input  cb_pkg::cb_data_t         mem_wr_data,
  output cb_pkg::cb_data_t [L-1:0] cb_data,
  output logic [L-1:0]             cb_valid
);
  import cb_pkg::*;

  // words per bank
  localparam int DEPTH = 1 << CB_AW;

  for (genvar i = 0; i < L; i++) begin : g_bank
    cb_data_t mem [DEPTH];
    cb_data_t rd_q;
    logic     wr_sel;

    // host write to this bank only
    assign wr_sel = mem_wr_en && (mem_wr_bank == cb_bank_t'(i));

    always_ff @(posedge clk) begin
      if (wr_sel) begin
        mem[mem_wr_addr] <= mem_wr_data;
      end
    end

    // read only on an enabled slot
    always_ff @(posedge clk) begin
      if (cb_en[i]) begin
        rd_q <= mem[cb_addr[i]];
      end
    end

    assign cb_data[i] = rd_q;
  end

  // valid lines up with the read data
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cb_valid <= '0;
    end else begin
      cb_valid <= cb_en;
    end
  end

endmodule

//--- design/cb_dist_top.sv
`timescale 1ns/1ps
// codebook address distributor top
// host registers, issue FSM, shift chain, bank reads
module cb_dist_top #(
  parameter int L = 4,
  parameter int GROUP_LEN = 4
) (
  input  logic                     clk,
  input  logic                     sys_rst,
  input  cb_pkg::wb_adr_t          wb_adr,
  input  cb_pkg::wb_data_t         wb_dat_w,
  output cb_pkg::wb_data_t         wb_dat_r,
  input  logic                     wb_we,
  input  logic                     wb_stb,
  input  logic                     wb_cyc,
  output logic                     wb_ack,
  output logic                     busy,
  output cb_pkg::cb_data_t [L-1:0] cb_data,
  output logic [L-1:0]             cb_valid
);
  import cb_pkg::*;

  // host side
  cb_run_cfg_s run_cfg;
  logic        start;
  logic        mem_wr_en;
  cb_bank_t    mem_wr_bank;
  cb_addr_t    mem_wr_addr;
  cb_data_t    mem_wr_data;

  // address pipeline
  cb_beat_s          beat;
  cb_dir_e           run_dir;
  cb_addr_t [L-1:0]  cb_addr;
  logic [L-1:0]      cb_en;

  cb_wb_regs i_cb_wb_regs (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_we       (wb_we),
    .wb_stb      (wb_stb),
    .wb_cyc      (wb_cyc),
    .busy        (busy),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .run_cfg     (run_cfg),
    .start       (start),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_bank (mem_wr_bank),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data)
  );

  // drain length follows the bank count
  cb_addr_issue #(
    .GROUP_LEN (GROUP_LEN),
    .L         (L)
  ) i_cb_addr_issue (
    .clk     (clk),
    .sys_rst (sys_rst),
    .start   (start),
    .run_cfg (run_cfg),
    .beat    (beat),
    .run_dir (run_dir),
    .busy    (busy)
  );

  cb_addr_shift #(
    .L (L)
  ) i_cb_addr_shift (
    .clk     (clk),
    .sys_rst (sys_rst),
    .run_dir (run_dir),
    .beat    (beat),
    .cb_addr (cb_addr),
    .cb_en   (cb_en)
  );

  cb_bank_read #(
    .L (L)
  ) i_cb_bank_read (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .cb_addr     (cb_addr),
    .cb_en       (cb_en),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_bank (mem_wr_bank),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .cb_data     (cb_data),
    .cb_valid    (cb_valid)
  );

endmodule

//--- design/cb_pkg.sv
// shared definitions for the codebook address distributor
// address, data and bus widths, direction and issue state enums
// issue beat and run config structs, register map constants
package cb_pkg;

  // word address inside one bank, arithmetic wraps mod 256
  localparam int CB_AW = 8;
  typedef logic [CB_AW-1:0] cb_addr_t;

  // one codebook word
  localparam int CB_DW = 16;
  typedef logic [CB_DW-1:0] cb_data_t;

  // wishbone host port
  localparam int WB_AW = 16;
  localparam int WB_DW = 16;
  typedef logic [WB_AW-1:0] wb_adr_t;
  typedef logic [WB_DW-1:0] wb_data_t;

  // bank select field of a codebook window address
  localparam int CB_BANK_W = 3;
  localparam int CB_BANK_LSB = 12;
  typedef logic [CB_BANK_W-1:0] cb_bank_t;

  // run length in beats
  localparam int RUN_LEN_W = 16;
  typedef logic [RUN_LEN_W-1:0] run_len_t;

  // direction modes, encoding matches the shift chain
  typedef enum logic [1:0] {
    DIR_IDLE  = 2'b00,
    DIR_POS   = 2'b01,
    DIR_NEW_0 = 2'b10,
    DIR_NEW_1 = 2'b11
  } cb_dir_e;

  typedef enum logic [1:0] {
    ISSUE_IDLE,
    ISSUE_RUN,
    ISSUE_DRAIN
  } issue_state_e;

  // one issue beat
  typedef struct packed {
    logic     en_new;
    cb_addr_t addr_new;
    logic     group_cnt_0;
  } cb_beat_s;

  typedef struct packed {
    cb_dir_e  dir;
    cb_addr_t base;
    run_len_t len;
  } cb_run_cfg_s;

  // register word offsets, taken from wb_adr[1:0]
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_BASE   = 2'd1;
  localparam logic [1:0] REG_LEN    = 2'd2;
  localparam logic [1:0] REG_STATUS = 2'd3;

  // ctrl: dir in [1:0], start in bit 2
  localparam int CTRL_START_BIT = 2;

  // set in wb_adr selects codebook memory
  localparam int CB_WIN_BIT = 15;

endpackage

//--- design/cb_wb_regs.sv
`timescale 1ns/1ps
// wishbone classic slave for the codebook distributor
// ctrl/base/len/status registers, start pulse, codebook write decode
module cb_wb_regs (
  input  logic                clk,
  input  logic                sys_rst,
  input  cb_pkg::wb_adr_t     wb_adr,
  input  cb_pkg::wb_data_t    wb_dat_w,
  input  logic                wb_we,
  input  logic                wb_stb,
  input  logic                wb_cyc,
  input  logic                busy,
  output cb_pkg::wb_data_t    wb_dat_r,
  output logic                wb_ack,
  output cb_pkg::cb_run_cfg_s run_cfg,
  output logic                start,
  output logic                mem_wr_en,
  output cb_pkg::cb_bank_t    mem_wr_bank,
  output cb_pkg::cb_addr_t    mem_wr_addr,
  output cb_pkg::cb_data_t    mem_wr_data
);
  import cb_pkg::*;

  logic       win_sel;
  logic       wr_fire;
  logic       reg_wr;
  logic [1:0] reg_sel;

  assign win_sel = wb_adr[CB_WIN_BIT];
  assign reg_sel = wb_adr[1:0];

  // write lands on the ack cycle
  assign wr_fire = wb_cyc & wb_stb & wb_we & wb_ack;
  assign reg_wr  = wr_fire & ~win_sel;

  // one wait state, ack high for a single cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc & wb_stb & ~wb_ack;
    end
  end

  // run settings
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      run_cfg <= '0;
    end else if (reg_wr) begin
      case (reg_sel)
        REG_CTRL: run_cfg.dir  <= cb_dir_e'(wb_dat_w[1:0]);
        REG_BASE: run_cfg.base <= wb_dat_w[CB_AW-1:0];
        REG_LEN:  run_cfg.len  <= wb_dat_w;
        default:  ;
      endcase
    end
  end

  // start goes out with the new settings already in place
  // dropped while a run is in flight
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      start <= 1'b0;
    end else begin
      start <= reg_wr && (reg_sel == REG_CTRL) && wb_dat_w[CTRL_START_BIT] && !busy;
    end
  end

  // register read mux, window reads give zero
  always_comb begin
    wb_dat_r = '0;
    if (!win_sel) begin
      case (reg_sel)
        REG_CTRL:   wb_dat_r[1:0] = run_cfg.dir;
        REG_BASE:   wb_dat_r[CB_AW-1:0] = run_cfg.base;
        REG_LEN:    wb_dat_r = run_cfg.len;
        REG_STATUS: wb_dat_r[0] = busy;
        default:    wb_dat_r = '0;
      endcase
    end
  end

  // codebook window: bank in [14:12], word in [7:0]
  assign mem_wr_en   = wr_fire & win_sel;
  assign mem_wr_bank = wb_adr[CB_BANK_LSB +: CB_BANK_W];
  assign mem_wr_addr = wb_adr[CB_AW-1:0];
  assign mem_wr_data = wb_dat_w;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the distributor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cb_dist_tb -f verilog.f -o cb_dist_sim
./obj_dir/cb_dist_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "run_sim: pass"
  exit 0
fi
echo "run_sim: fail"
exit 1

//--- sim/cb_dist_sva.sv
`timescale 1ns/1ps
// bound checks on the wishbone handshake and the bank valid stream
module cb_dist_sva #(
  parameter int L = 4
) (
  input logic         clk,
  input logic         sys_rst,
  input logic         wb_cyc,
  input logic         wb_stb,
  input logic         wb_ack,
  input logic         busy,
  input logic [L-1:0] cb_valid
);

  // ack lasts one cycle
  ack_single: assert property (@(posedge clk) disable iff (sys_rst)
    wb_ack |=> !wb_ack)
    else $error("wb_ack high two cycles in a row");

  // ack answers a request
  ack_after_req: assert property (@(posedge clk) disable iff (sys_rst)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without a preceding cyc and stb");

  // reset clears every valid
  valid_in_reset: assert property (@(posedge clk)
    $past(sys_rst) |-> cb_valid == '0)
    else $error("cb_valid set during reset");

  // new valid only within three cycles of busy
  valid_near_busy: assert property (@(posedge clk) disable iff (sys_rst)
    |(cb_valid & ~$past(cb_valid)) |-> busy || $past(busy) || $past(busy, 2) || $past(busy, 3))
    else $error("cb_valid rose long after busy fell");

endmodule

bind cb_dist_top cb_dist_sva #(
  .L (L)
) i_cb_dist_sva (
  .clk      (clk),
  .sys_rst  (sys_rst),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .busy     (busy),
  .cb_valid (cb_valid)
);

//--- sim/cb_dist_tb.sv
`timescale 1ns/1ps
// testbench for the codebook address distributor
// wishbone master tasks, input file driver, per-bank stream model and monitor
// cycle watchdog with a limit grown from the records
module cb_dist_tb;
  import cb_pkg::*;

  localparam int L = 4;
  localparam int GROUP_LEN = 4;
  localparam logic [31:0] SEED = 32'h0c878f19;

  logic             clk;
  logic             sys_rst;
  wb_adr_t          wb_adr;
  wb_data_t         wb_dat_w;
  wb_data_t         wb_dat_r;
  logic             wb_we;
  logic             wb_stb;
  logic             wb_cyc;
  logic             wb_ack;
  logic             busy;
  cb_data_t [L-1:0] cb_data;
  logic [L-1:0]     cb_valid;

  // host copy of every bank
  cb_data_t    shadow [L][256];
  logic [31:0] lcg_state;

  // run in flight as seen by the monitor
  cb_run_cfg_s cur_run;
  int          cur_exp;
  logic        run_active;
  int          got_cnt [L];

  int checks;
  int value_errs;
  int other_errs;
  int cycle_cnt;
  int cycle_limit;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  cb_dist_top #(
    .L         (L),
    .GROUP_LEN (GROUP_LEN)
  ) i_cb_dist_top (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_we    (wb_we),
    .wb_stb   (wb_stb),
    .wb_cyc   (wb_cyc),
    .wb_ack   (wb_ack),
    .busy     (busy),
    .cb_data  (cb_data),
    .cb_valid (cb_valid)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic wb_adr_t reg_adr(input logic [1:0] r);
    return wb_adr_t'(r);
  endfunction

  // window bit set with the bank in [14:12] and the word in [7:0]
  function automatic wb_adr_t win_adr(input int bank, input cb_addr_t addr);
    return {1'b1, 3'(bank), 4'b0000, addr};
  endfunction

  // bank i sees base + k plus i on odd groups in positive mode
  function automatic cb_addr_t exp_addr(input cb_run_cfg_s run, input int k, input int bank);
    int g;
    g = (k / GROUP_LEN) % 2;
    if (run.dir == DIR_POS) begin
      return cb_addr_t'(int'(run.base) + k + bank * g);
    end
    return cb_addr_t'(int'(run.base) + k);
  endfunction

  function automatic logic bank_active(input cb_dir_e dir, input int bank);
    case (dir)
      DIR_POS:   return 1'b1;
      DIR_NEW_1: return bank < 2;
      DIR_NEW_0: return bank == 2 || bank == 3;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      value_errs++;
      $display("CHECK FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      other_errs++;
      $display("ERROR t=%0t %s", $time, what);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errs, other_errs);
  endtask

  // one classic cycle held until ack and released after the ack cycle
  task automatic bus_access(input wb_adr_t adr, input logic we, input wb_data_t dat,
                            output wb_data_t rdata);
    cycle_limit += 100;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (wb_ack !== 1'b1);
    rdata = wb_dat_r;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input wb_adr_t adr, input wb_data_t dat);
    wb_data_t unused_rd;
    bus_access(adr, 1'b1, dat, unused_rd);
  endtask

  task automatic bus_read(input wb_adr_t adr, output wb_data_t dat);
    bus_access(adr, 1'b0, '0, dat);
  endtask

  task automatic fill_word(input int bank, input cb_addr_t addr, input cb_data_t data);
    bus_write(win_adr(bank, addr), data);
    shadow[bank][addr] = data;
  endtask

  // random top bits with bank and word in the low bits
  task automatic fill_bank(input int bank);
    cb_data_t w;
    for (int a = 0; a < 256; a++) begin
      lcg_state = lcg_next(lcg_state);
      w = {lcg_state[20:16], 3'(bank), 8'(a)};
      fill_word(bank, cb_addr_t'(a), w);
    end
  endtask

  task automatic do_run(input cb_run_cfg_s run, input int exp_cnt, input logic restart);
    wb_data_t rd;
    int       wait_cyc;
    cur_run = run;
    cur_exp = exp_cnt;
    for (int i = 0; i < L; i++) begin
      got_cnt[i] = 0;
    end
    run_active = 1'b1;
    cycle_limit += int'(run.len) + L + 40;
    bus_write(reg_adr(REG_BASE), wb_data_t'(run.base));
    bus_write(reg_adr(REG_LEN), run.len);
    bus_write(reg_adr(REG_CTRL), {13'b0, 1'b1, run.dir});
    wait_cyc = 0;
    while (!busy && wait_cyc < 4) begin
      @(posedge clk);
      #1;
      wait_cyc++;
    end
    check_cond(busy, "busy did not rise after start");
    // status bit 0 shows the run in flight
    bus_read(reg_adr(REG_STATUS), rd);
    check_value("wb_dat_r status during run", 32'(rd), 1);
    if (restart) begin
      // second start mid-run with another length
      bus_write(reg_adr(REG_LEN), run.len + 16'd5);
      bus_write(reg_adr(REG_CTRL), {13'b0, 1'b1, run.dir});
      check_cond(busy, "run ended before the second start was written");
    end
    while (busy) begin
      @(posedge clk);
      #1;
    end
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < L; i++) begin
      check_value($sformatf("valid count bank %0d", i), got_cnt[i],
                  bank_active(run.dir, i) ? exp_cnt : 0);
    end
    bus_read(reg_adr(REG_STATUS), rd);
    check_value("wb_dat_r status", 32'(rd), 0);
    run_active = 1'b0;
  endtask

  // per-bank stream monitor on the falling edge
  always @(negedge clk) begin
    for (int i = 0; i < L; i++) begin
      if (!sys_rst && cb_valid[i]) begin
        if (!run_active || !bank_active(cur_run.dir, i) || got_cnt[i] >= cur_exp) begin
          check_cond(1'b0, $sformatf("unexpected valid on bank %0d", i));
        end else begin
          check_value($sformatf("cb_data[%0d] beat %0d", i, got_cnt[i]), 32'(cb_data[i]),
                      32'(shadow[i][exp_addr(cur_run, got_cnt[i], i)]));
        end
        got_cnt[i]++;
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("ERROR: timeout, no progress after %0d cycles", cycle_cnt);
      report_counts();
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int          fd;
    int          c;
    int          n;
    int          kind;
    int          f1;
    int          f2;
    int          f3;
    int          f4;
    int          f5;
    cb_run_cfg_s run;
    wb_data_t    rd;
    sys_rst     = 1'b1;
    wb_adr      = '0;
    wb_dat_w    = '0;
    wb_we       = 1'b0;
    wb_stb      = 1'b0;
    wb_cyc      = 1'b0;
    checks      = 0;
    value_errs  = 0;
    other_errs  = 0;
    cycle_cnt   = 0;
    cycle_limit = 8 + 20;
    lcg_state   = SEED;
    run_active  = 1'b0;
    cur_run     = '0;
    cur_exp     = 0;
    for (int i = 0; i < L; i++) begin
      got_cnt[i] = 0;
    end
    repeat (8) @(posedge clk);
    #1;
    sys_rst = 1'b0;

    // idle state after reset
    check_value("busy", 32'(busy), 0);
    check_value("wb_ack", 32'(wb_ack), 0);
    check_value("cb_valid", 32'(cb_valid), 0);
    bus_read(reg_adr(REG_STATUS), rd);
    check_value("wb_dat_r status", 32'(rd), 0);

    fd = $fopen("sim/cb_input.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("ERROR: cannot open sim/cb_input.txt");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == 35) begin
          // comment to end of line
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end else if (c > 32) begin
          // single digit record kind
          kind = c - 48;
          if (kind == 1) begin
            n = $fscanf(fd, "%d %h %h", f1, f2, f3);
            check_cond(n == 3, "short fill record in input file");
            fill_word(f1, cb_addr_t'(f2), cb_data_t'(f3));
          end else if (kind == 2) begin
            n = $fscanf(fd, "%d", f1);
            check_cond(n == 1, "short bulk record in input file");
            fill_bank(f1);
          end else if (kind == 3) begin
            n = $fscanf(fd, "%d %h %d %d %d", f1, f2, f3, f4, f5);
            check_cond(n == 5, "short run record in input file");
            run.dir  = cb_dir_e'(f1[1:0]);
            run.base = cb_addr_t'(f2);
            run.len  = run_len_t'(f3);
            do_run(run, f4, f5[0]);
          end else begin
            check_cond(1'b0, "unknown record kind in input file");
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end

    report_counts();
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim/cb_input.txt
# 1 <bank> <word hex> <data hex>      single codebook word
# 2 <bank>                            bulk fill, 256 words | 3 <dir> <base hex> <len> <exp> <restart>
# dir codes: 1 positive, 2 new_0 (banks 2,3), 3 new_1 (banks 0,1)
2 0
2 1
2 2
2 3
# hand-placed words near the wrap point
1 0 ff beef
1 1 00 cafe
1 2 fe 1234
1 3 02 abcd
# positive run, steps on odd groups
3 1 10 12 12 0
# bank pair runs
3 3 40 9 9 0
3 2 80 9 9 0
# addresses cross 255
3 1 f8 16 16 0
3 3 fc 8 8 0
3 2 fa 10 10 0
# second start while busy is dropped
3 1 20 12 12 1
# zero length
3 1 00 0 0 0
# normal run afterwards
3 1 05 5 5 0

//--- verilog.f
design/cb_pkg.sv
design/cb_wb_regs.sv
design/cb_addr_issue.sv
design/cb_addr_shift.sv
design/cb_bank_read.sv
design/cb_dist_top.sv
sim/cb_dist_sva.sv
sim/cb_dist_tb.sv
